/* Bender.yml */
package:
  name: obstacle_gen

sources:
  - include_dirs:
      - include
    files:
      - hdl/obstacle_pkg.sv
      - hdl/frame_lfsr.sv
      - hdl/obstacle_motion.sv
      - hdl/beam_window.sv
      - hdl/pixel_compositor.sv
      - hdl/obstacle_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - tb/clk_gen.sv
      - tb/obstacle_props.sv
      - tb/obstacle_tb.sv

/* hdl/beam_window.sv */
module beam_window (
    input  logic                RESET,
    input  logic                arst_n,
    input  obstacle_pkg::scan_t scan,
    output obstacle_pkg::scan_t scan_q,
    output logic                in_band
);

    logic row_hit;

    // rows covered by the sprite
    assign row_hit = (scan.row >= 9'(obstacle_pkg::band_top)) &&
                     (scan.row <= 9'(obstacle_pkg::band_top + obstacle_pkg::sprite_h - 1));

    always_ff @(posedge RESET) begin
        scan_q <= scan;
    end

    always_ff @(posedge RESET or negedge arst_n) begin
        if (!arst_n) begin
            in_band <= 1'b0;
        end else begin
            in_band <= row_hit; // lines up with scan_q
        end
    end

endmodule

/* hdl/frame_lfsr.sv */
module frame_lfsr (
    input  logic       RESET,
    input  logic       arst_n,
    input  logic       frame_tick,
    output logic [3:0] rnd
);

    // x^4 + x^3 + 1 in fibonacci form, runs through all 15 nonzero states
    always_ff @(posedge RESET or negedge arst_n) begin
        if (!arst_n) begin
            rnd <= 4'd1; // any nonzero seed works
        end else if (frame_tick) begin
            rnd <= {rnd[2:0], rnd[3] ^ rnd[2]};
        end
    end

endmodule

/* hdl/obstacle_motion.sv */
module obstacle_motion (
    input  logic                    RESET,
    input  logic                    arst_n,
    input  logic                    frame_tick,
    input  logic                    game_active,
    input  logic                    start,
    input  obstacle_pkg::speed_t    speed,
    output obstacle_pkg::obstacle_t obstacle
);

    logic [3:0]          rnd;
    obstacle_pkg::pos_t  pos_q;
    obstacle_pkg::kind_t kind_q;
    logic [9:0]          wait_cnt;
    logic [9:0]          wait_time;
    logic [10:0]         pos_sum;
    obstacle_pkg::pos_t  pos_next;

    frame_lfsr i_lfsr (
        .RESET      (RESET),
        .arst_n     (arst_n),
        .frame_tick (frame_tick),
        .rnd        (rnd)
    );

    // scroll step modulo the track span
    assign pos_sum  = {1'b0, pos_q} + {7'd0, speed};
    assign pos_next = (pos_sum >= 11'(obstacle_pkg::track_span))
                    ? obstacle_pkg::pos_t'(pos_sum - 11'(obstacle_pkg::track_span))
                    : obstacle_pkg::pos_t'(pos_sum);

    always_ff @(posedge RESET or negedge arst_n) begin
        if (!arst_n) begin
            pos_q     <= '0;
            kind_q    <= '0;
            wait_cnt  <= '0;
            wait_time <= '0;
        end else if (frame_tick) begin
            if (game_active) begin
                if (pos_q == '0) begin
                    if (wait_cnt == '0) begin
                        // pick the next obstacle and how long to hold it back
                        wait_time <= 10'(rnd * obstacle_pkg::wait_step);
                        kind_q    <= obstacle_pkg::kind_t'(rnd % obstacle_pkg::num_kinds);
                        wait_cnt  <= 10'd1;
                    end else if (wait_cnt >= wait_time) begin
                        pos_q    <= obstacle_pkg::pos_t'(speed); // enters at the right edge
                        wait_cnt <= '0;
                    end else begin
                        wait_cnt <= wait_cnt + 10'd1;
                    end
                end else begin
                    pos_q <= pos_next;
                end
            end else if (start) begin
                // restart after game over keeps the kind
                pos_q     <= '0;
                wait_cnt  <= '0;
                wait_time <= '0;
            end
        end
    end

    assign obstacle.pos  = pos_q;
    assign obstacle.kind = kind_q;

endmodule

/* hdl/obstacle_pkg.sv */
package obstacle_pkg;

    // raster and sprite geometry
    localparam int screen_w   = 640;
    localparam int sprite_w   = 16;
    localparam int sprite_h   = 16;
    localparam int track_span = screen_w + sprite_w; // obstacle is fully off the left edge here
    localparam int band_top   = 344;                 // sprite sits on the ground line

    // wait between obstacles
    localparam int wait_step  = 10;                  // frames per lfsr unit
    localparam int num_kinds  = 3;

    // 0 means hidden, otherwise pixels travelled from the right edge
    typedef logic [9:0] pos_t;

    // 0 grass, 1 cactus, 2 snake
    typedef logic [1:0] kind_t;

    typedef logic [3:0] speed_t;                     // pixels per frame

    // raster position supplied by the video timing
    typedef struct packed {
        logic [8:0] row;
        logic [9:0] col;
    } scan_t;

    // what a collision detector needs to know
    typedef struct packed {
        pos_t  pos;
        kind_t kind;
    } obstacle_t;

endpackage

/* hdl/obstacle_top.sv */
module obstacle_top (
    input  logic                    RESET,
    input  logic                    arst_n,
    input  logic                    frame_tick,
    input  logic                    game_active,
    input  logic                    start,
    input  obstacle_pkg::speed_t    speed,
    input  obstacle_pkg::scan_t     scan,
    output obstacle_pkg::obstacle_t obstacle,
    output logic                    px
);

    obstacle_pkg::scan_t scan_q;
    logic                in_band;

    // once per frame
    obstacle_motion i_motion (
        .RESET       (RESET),
        .arst_n      (arst_n),
        .frame_tick  (frame_tick),
        .game_active (game_active),
        .start       (start),
        .speed       (speed),
        .obstacle    (obstacle)
    );

    // once per pixel
    beam_window i_window (
        .RESET   (RESET),
        .arst_n  (arst_n),
        .scan    (scan),
        .scan_q  (scan_q),
        .in_band (in_band)
    );

    pixel_compositor i_compositor (
        .RESET    (RESET),
        .arst_n   (arst_n),
        .scan_q   (scan_q),
        .in_band  (in_band),
        .obstacle (obstacle),
        .px       (px)
    );

endmodule

/* hdl/pixel_compositor.sv */
module pixel_compositor (
    input  logic                    RESET,
    input  logic                    arst_n,
    input  obstacle_pkg::scan_t     scan_q,
    input  logic                    in_band,
    input  obstacle_pkg::obstacle_t obstacle,
    output logic                    px
);

    `include "sprite_rom.svh"

    logic [10:0] x_track;  // column in track coordinates
    logic        col_hit;
    logic [3:0]  spr_row;
    logic [3:0]  spr_col;
    logic        shown;

    // screen_w - pos <= col < screen_w + sprite_w - pos, kept unsigned
    assign x_track = {1'b0, scan_q.col} + {1'b0, obstacle.pos};
    assign col_hit = (x_track >= 11'(obstacle_pkg::screen_w)) &&
                     (x_track < 11'(obstacle_pkg::screen_w + obstacle_pkg::sprite_w));

    assign spr_row = 4'(scan_q.row - 9'(obstacle_pkg::band_top));
    assign spr_col = 4'(x_track - 11'(obstacle_pkg::screen_w));

    assign shown = in_band && (obstacle.pos != '0) && col_hit;

    always_ff @(posedge RESET or negedge arst_n) begin
        if (!arst_n) begin
            px <= 1'b0;
        end else begin
            px <= shown && sprite_bit(obstacle.kind, spr_row, spr_col);
        end
    end

endmodule

/* include/sprite_rom.svh */
// one bit of a 16x16 sprite
// bit 15 of a line is the leftmost column
// blank rows and the unused kind fall through to the default
function automatic logic sprite_bit(
    input obstacle_pkg::kind_t kind,
    input logic [3:0]          row,
    input logic [3:0]          col
);
    logic [obstacle_pkg::sprite_w-1:0] line;
    case ({kind, row})
        // grass
        6'h06: line = 16'b0000_0001_0000_0000;
        6'h07: line = 16'b0000_0001_0001_0000;
        6'h08: line = 16'b0010_0001_1001_0000;
        6'h09: line = 16'b0010_0101_0011_0000;
        6'h0a: line = 16'b0011_0101_0011_0100;
        6'h0b: line = 16'b0001_0101_0110_0100;
        6'h0c: line = 16'b0101_1101_1110_1100;
        6'h0d: line = 16'b0101_1111_1110_1110;
        6'h0e: line = 16'b0111_1111_1111_1110;
        6'h0f: line = 16'b1111_1111_1111_1111;
        // cactus
        6'h10: line = 16'b0000_0011_1100_0000;
        6'h11: line = 16'b0000_0111_1110_0000;
        6'h12: line = 16'b0000_0111_1110_0000;
        6'h13: line = 16'b0110_0111_1110_0000;
        6'h14: line = 16'b1111_0111_1110_0000;
        6'h15: line = 16'b1111_0111_1110_0110;
        6'h16: line = 16'b1111_0111_1110_1111;
        6'h17: line = 16'b1111_1111_1110_1111;
        6'h18: line = 16'b0111_1111_1110_1111;
        6'h19: line = 16'b0011_1111_1111_1111;
        6'h1a: line = 16'b0000_0111_1111_1110;
        6'h1b: line = 16'b0000_0111_1111_1100;
        6'h1c, 6'h1d, 6'h1e, 6'h1f: line = 16'b0000_0111_1110_0000; // trunk
        // snake with the head up and the body coiled below
        6'h22: line = 16'b0001_1111_0000_0000;
        6'h23: line = 16'b0011_0001_1000_0000;
        6'h24: line = 16'b0110_1010_1100_0000;
        6'h25: line = 16'b0110_0000_1100_0000;
        6'h26: line = 16'b0011_1111_1000_0000;
        6'h27: line = 16'b0001_1001_0000_0000;
        6'h28: line = 16'b0000_0110_0000_0000;
        6'h29: line = 16'b0000_1100_0000_0000;
        6'h2a: line = 16'b0000_1100_0000_0000;
        6'h2b: line = 16'b0000_0110_0000_0110;
        6'h2c: line = 16'b0000_0011_1000_1100;
        6'h2d: line = 16'b0000_0001_1111_1000;
        6'h2e: line = 16'b0011_1111_1111_1100;
        6'h2f: line = 16'b0111_1111_1111_1110;
        default: line = '0;
    endcase
    return line[obstacle_pkg::sprite_w - 1 - col];
endfunction

/* tb.f */
+incdir+include
hdl/obstacle_pkg.sv
hdl/frame_lfsr.sv
hdl/obstacle_motion.sv
hdl/beam_window.sv
hdl/pixel_compositor.sv
hdl/obstacle_top.sv
tb/clk_gen.sv
tb/obstacle_props.sv
tb/obstacle_tb.sv

/* tb/clk_gen.sv */
module clk_gen (
    output logic RESET,
    output logic arst_n
);

    initial begin
        RESET = 1'b0;
        forever #5 RESET = ~RESET;
    end

    // held low for four rising edges, released just after the fourth
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge RESET);
        #1 arst_n = 1'b1;
    end

endmodule

/* tb/obstacle_props.sv */
module obstacle_props (
    input logic                    RESET,
    input logic                    arst_n,
    input logic                    frame_tick,
    input logic                    game_active,
    input logic                    start,
    input obstacle_pkg::speed_t    speed,
    input obstacle_pkg::scan_t     scan,
    input obstacle_pkg::obstacle_t obstacle,
    input logic                    px
);

    `include "sprite_rom.svh"

    int fail_count = 0;

    obstacle_pkg::obstacle_t obs_d;   // obstacle one cycle back
    obstacle_pkg::speed_t    speed_d;
    obstacle_pkg::scan_t     scan_d;  // scan one cycle back
    logic                    step_d;
    logic                    hold_d;
    logic                    clear_d;
    logic                    win_d;
    logic                    exp_px;
    int                      exp_pos;

    // row band and column window of the obstacle at position p
    function automatic logic window_hit(obstacle_pkg::scan_t s, obstacle_pkg::pos_t p);
        int row;
        int x;
        row = int'(s.row);
        x   = int'(s.col) + int'(p);
        return (p != '0) &&
               (row >= obstacle_pkg::band_top) &&
               (row < obstacle_pkg::band_top + obstacle_pkg::sprite_h) &&
               (x >= obstacle_pkg::screen_w) &&
               (x < obstacle_pkg::screen_w + obstacle_pkg::sprite_w);
    endfunction

    function automatic logic expected_px(obstacle_pkg::scan_t s, obstacle_pkg::obstacle_t o);
        int spr_row;
        int spr_col;
        spr_row = int'(s.row) - obstacle_pkg::band_top;
        spr_col = int'(s.col) + int'(o.pos) - obstacle_pkg::screen_w;
        if (!window_hit(s, o.pos))
            return 1'b0;
        return sprite_bit(o.kind, 4'(spr_row), 4'(spr_col));
    endfunction

    always_ff @(posedge RESET or negedge arst_n) begin
        if (!arst_n) begin
            obs_d   <= '0;
            speed_d <= '0;
            scan_d  <= '0;  // row 0 lies outside the band
            step_d  <= 1'b0;
            hold_d  <= 1'b0;
            clear_d <= 1'b0;
            win_d   <= 1'b0;
            exp_px  <= 1'b0;
            exp_pos <= 0;
        end else begin
            obs_d   <= obstacle;
            speed_d <= speed;
            scan_d  <= scan;
            step_d  <= frame_tick && game_active && (obstacle.pos != '0);
            exp_pos <= (int'(obstacle.pos) + int'(speed)) % obstacle_pkg::track_span;
            hold_d  <= !(frame_tick && (game_active || start));
            clear_d <= frame_tick && !game_active && start;
            win_d   <= window_hit(scan_d, obstacle.pos);
            exp_px  <= expected_px(scan_d, obstacle);
        end
    end

    reset_clear: assert property (@(posedge RESET)
        $rose(arst_n) |-> (px == 1'b0) && (obstacle.pos == '0) && (obstacle.kind == '0))
    else begin
        fail_count++;
        $error("CHECK FAILED reset px %h pos %h kind %h", $sampled(px),
               $sampled(obstacle.pos), $sampled(obstacle.kind));
    end

    pos_step: assert property (@(posedge RESET) disable iff (!arst_n)
        step_d |-> int'(obstacle.pos) == exp_pos)
    else begin
        fail_count++;
        $error("CHECK FAILED pos expected %h got %h", $sampled(exp_pos), $sampled(obstacle.pos));
    end

    kind_range: assert property (@(posedge RESET) disable iff (!arst_n)
        obstacle.kind < 2'(obstacle_pkg::num_kinds))
    else begin
        fail_count++;
        $error("CHECK FAILED obstacle.kind got %h", $sampled(obstacle.kind));
    end

    kind_hidden: assert property (@(posedge RESET) disable iff (!arst_n)
        (obstacle.kind != obs_d.kind) |-> (obs_d.pos == '0))
    else begin
        fail_count++;
        $error("sprite kind changed while the obstacle was on the track");
    end

    // a new obstacle enters one speed step in from the right edge
    appear_at_speed: assert property (@(posedge RESET) disable iff (!arst_n)
        (obs_d.pos == '0) && (obstacle.pos != '0) |-> obstacle.pos == 10'(speed_d))
    else begin
        fail_count++;
        $error("CHECK FAILED pos on appear expected %h got %h", $sampled(speed_d),
               $sampled(obstacle.pos));
    end

    px_in_window: assert property (@(posedge RESET) disable iff (!arst_n)
        px |-> win_d)
    else begin
        fail_count++;
        $error("pixel set outside the obstacle row band or column window");
    end

    px_value: assert property (@(posedge RESET) disable iff (!arst_n)
        win_d |-> px == exp_px)
    else begin
        fail_count++;
        $error("CHECK FAILED px expected %h got %h", $sampled(exp_px), $sampled(px));
    end

    pos_hold: assert property (@(posedge RESET) disable iff (!arst_n)
        hold_d |-> obstacle.pos == obs_d.pos)
    else begin
        fail_count++;
        $error("CHECK FAILED pos held expected %h got %h", $sampled(obs_d.pos),
               $sampled(obstacle.pos));
    end

    pos_restart: assert property (@(posedge RESET) disable iff (!arst_n)
        clear_d |-> obstacle.pos == '0)
    else begin
        fail_count++;
        $error("CHECK FAILED pos after start expected 0 got %h", $sampled(obstacle.pos));
    end

endmodule

/* tb/obstacle_tb.sv */
module obstacle_tb;

    localparam int frame_len   = 8;
    localparam int lfsr_period = 15;
    localparam int max_cycles  = 400 * frame_len + 200;

    logic                    RESET;
    logic                    arst_n;
    logic                    frame_tick;
    logic                    game_active;
    logic                    start;
    obstacle_pkg::speed_t    speed;
    obstacle_pkg::scan_t     scan;
    obstacle_pkg::obstacle_t obstacle;
    logic                    px;
    int                      tick_count;
    int                      cycle_count = 0;
    logic [2:0]              kind_seen = '0;  // one flag per sprite kind with a set pixel

    clk_gen i_clk_gen (
        .RESET  (RESET),
        .arst_n (arst_n)
    );

    obstacle_top i_obstacle_top (
        .RESET       (RESET),
        .arst_n      (arst_n),
        .frame_tick  (frame_tick),
        .game_active (game_active),
        .start       (start),
        .speed       (speed),
        .scan        (scan),
        .obstacle    (obstacle),
        .px          (px)
    );

    bind obstacle_top obstacle_props i_props (.*);

    // aim the beam at the band rows and the columns around the obstacle
    function automatic obstacle_pkg::scan_t next_scan();
        obstacle_pkg::scan_t s;
        int col;
        s.row = 9'(obstacle_pkg::band_top - 2 + $urandom % (obstacle_pkg::sprite_h + 4));
        col = obstacle_pkg::screen_w - int'(obstacle.pos) - 3 + int'($urandom % 22);
        if (col < 0)
            col = 0;
        s.col = 10'(col);
        return s;
    endfunction

    task automatic run_frame(input logic active, input logic restart);
        int c;
        for (c = 0; c < frame_len; c++) begin
            @(posedge RESET);
            #1;
            frame_tick  = (c == 0);
            game_active = active;
            start       = restart;
            if (c == 0) begin
                speed = obstacle_pkg::speed_t'(1 + $urandom % 15);
                tick_count++;
            end
            scan = next_scan();
        end
    endtask

    // the lfsr phase at the first active tick picks the kind and the wait
    task automatic play_round(input int phase, input int visible_frames);
        int n;
        run_frame(1'b0, 1'b0);  // obstacle stays put while the game is over
        while ((tick_count + 1) % lfsr_period != phase)
            run_frame(1'b0, 1'b0);
        run_frame(1'b0, 1'b1);
        n = 0;
        while (obstacle.pos == '0 && n < 200) begin
            run_frame(1'b1, 1'b0);
            n++;
        end
        repeat (visible_frames) run_frame(1'b1, 1'b0);
    endtask

    always @(posedge RESET) begin
        if (px)
            kind_seen[obstacle.kind] <= 1'b1;
    end

    always @(posedge RESET) begin
        cycle_count <= cycle_count + 1;
        if (i_obstacle_top.i_props.fail_count != 0) begin
            $display("Checks failed");
            $fatal(1, "stopped at the first failing assertion");
        end else if (cycle_count >= max_cycles) begin
            $display("Checks failed");
            $fatal(1, "timeout after %0d cycles, stimulus did not finish", cycle_count);
        end
    end

    initial begin
        frame_tick  = 1'b0;
        game_active = 1'b0;
        start       = 1'b0;
        speed       = 4'd1;
        scan        = '0;
        tick_count  = 0;
        void'($urandom(33));

        @(posedge arst_n);
        play_round(1, 12);   // snake after a short wait
        play_round(4, 12);   // grass
        play_round(0, 100);  // cactus for long enough to wrap past the left edge
        repeat (4) @(posedge RESET);
        #1;

        if (kind_seen != 3'b111)
            $display("stimulus did not reach a set pixel of every sprite kind");
        if (kind_seen == 3'b111 && i_obstacle_top.i_props.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "run ended with failures");
        end
    end

endmodule
